/* filelist.f */
mult_pkg.sv
nibble_multiplier.sv
product_writer.sv
product_mem.sv
block_reader.sv
mult_block_top.sv
tb_mult_block.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the block product buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_mult_block -f filelist.f -o sim_mult_block
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

output="$(./obj_dir/sim_mult_block)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# pass only on the exact pass line
if echo "$output" | grep -qx "Testbench passed"; then
    exit 0
else
    exit 1
fi

/* tb_mult_block.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mult_block;

    import mult_pkg::*;

    // ==========================================================
    // test table
    // ==========================================================
    typedef struct packed {
        logic rand_fill;
        logic [1:0] gap_mode;
        logic [2:0] extra;
        logic early_read;
    } test_entry_t;

    test_entry_t tests [6];

    // corners, single nibble values, all ones
    logic [OPND_WIDTH-1:0] corner_vals [16] = '{
        16'h0000, 16'h0001, 16'hffff, 16'h000f,
        16'h00f0, 16'h0f00, 16'hf000, 16'h0008,
        16'h0080, 16'h0800, 16'h8000, 16'h0005,
        16'h00a0, 16'h0300, 16'hc000, 16'h7fff
    };

    // dut signals
    logic clk = 1'b0;
    logic rst;
    logic mult_en;
    operand_pair_u operands;
    logic block_read;
    logic mult_rdy;
    logic full;
    logic mem_valid;
    logic [PROD_WIDTH-1:0] mem_data;

    // expected products, acceptance order
    logic [PROD_WIDTH-1:0] exp_q [$];
    logic [31:0] rng_state;
    int mismatch_count;
    int other_count;
    int cycle_count = 0;
    int last_acc_cycle;
    logic draining;

    mult_block_top i_mult_block_top (
        .clk        (clk),
        .rst        (rst),
        .mult_en    (mult_en),
        .operands   (operands),
        .mult_rdy   (mult_rdy),
        .full       (full),
        .block_read (block_read),
        .mem_valid  (mem_valid),
        .mem_data   (mem_data)
    );

    // 20 ns period
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // words may only appear during a drain
    always @(negedge clk) begin
        if (!rst && mem_valid && !draining) begin
            $display("mem_valid high with no accepted block read at %0t", $time);
            other_count++;
        end
    end

    // ==========================================================
    // helpers
    // ==========================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // idle cycles after pair idx
    function automatic int gap_after(input logic [1:0] mode, input int idx);
        case (mode)
            2'd0: return 0;
            2'd1: return (idx * 5 + 3) % 4;
            // bursts of twelve, then the pipeline drains
            2'd2: return (idx % 12 == 11) ? 6 : 0;
            default: return (idx * idx * 7 + idx * 3) % 5;
        endcase
    endfunction

    task automatic expect_level(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("mismatch %s: got %h expected %h at %0t", name, got, want, $time);
            mismatch_count++;
        end
    endtask

    task automatic load_table();
        // fill mode, gap pattern, extra strobes, early read
        tests[0] = '{1'b0, 2'd0, 3'd3, 1'b1};
        tests[1] = '{1'b1, 2'd1, 3'd0, 1'b0};
        tests[2] = '{1'b1, 2'd2, 3'd2, 1'b1};
        tests[3] = '{1'b0, 2'd3, 3'd1, 1'b0};
        tests[4] = '{1'b1, 2'd0, 3'd4, 1'b1};
        tests[5] = '{1'b1, 2'd3, 3'd0, 1'b0};
    endtask

    // ==========================================================
    // fill one block, then the not-ready strobes
    // ==========================================================
    task automatic fill_block(input test_entry_t entry);
        operand_pair_u p;
        int lat;
        for (int i = 0; i < DEPTH; i++) begin
            if (entry.rand_fill) begin
                rng_state = xorshift32(rng_state);
                p = operand_pair_u'(rng_state);
            end else begin
                p.pair.a = corner_vals[i % 16];
                p.pair.b = corner_vals[(i % 16 + 3 * (i / 16)) % 16];
            end
            if (!mult_rdy) begin
                $display("mult_rdy low before pair %0d of the block", i);
                other_count++;
            end
            operands = p;
            mult_en = 1'b1;
            @(negedge clk);
            mult_en = 1'b0;
            exp_q.push_back(32'(p.pair.a) * 32'(p.pair.b));
            last_acc_cycle = cycle_count;
            if (i < DEPTH - 1) begin
                repeat (gap_after(entry.gap_mode, i)) @(negedge clk);
            end
        end
        expect_level("mult_rdy", mult_rdy, 1'b0);
        // these must not reach the block
        for (int n = 0; n < int'(entry.extra); n++) begin
            rng_state = xorshift32(rng_state);
            operands = operand_pair_u'(rng_state);
            mult_en = 1'b1;
            @(negedge clk);
            expect_level("mult_rdy", mult_rdy, 1'b0);
            expect_level("full", full, 1'b0);
        end
        mult_en = 1'b0;
        // read request while still filling, ignored
        if (entry.early_read) begin
            block_read = 1'b1;
            @(negedge clk);
            block_read = 1'b0;
            repeat (2) @(negedge clk);
        end
        lat = 0;
        while (!full && lat < 4 * MULT_LATENCY) begin
            @(negedge clk);
            lat++;
        end
        if (!full) begin
            $display("full never rose after the last accepted pair");
            other_count++;
        end else if (cycle_count - last_acc_cycle != MULT_LATENCY) begin
            $display("mismatch full delay: got %h expected %h",
                     cycle_count - last_acc_cycle, MULT_LATENCY);
            mismatch_count++;
        end
    endtask

    // ==========================================================
    // drain one block and compare
    // ==========================================================
    task automatic drain_block();
        int wait_cycles;
        logic [PROD_WIDTH-1:0] want;
        draining = 1'b1;
        block_read = 1'b1;
        @(negedge clk);
        block_read = 1'b0;
        wait_cycles = 0;
        while (!mem_valid && wait_cycles < 10) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (!mem_valid) begin
            $display("no mem_valid after the block read");
            other_count++;
        end else begin
            if (wait_cycles != 2) begin
                $display("mismatch mem_valid delay: got %h expected %h", wait_cycles, 2);
                mismatch_count++;
            end
            for (int n = 0; n < DEPTH; n++) begin
                want = exp_q.pop_front();
                if (!mem_valid) begin
                    $display("mem_valid dropped before word %0d of the block", n);
                    other_count++;
                end else if (mem_data !== want) begin
                    $display("mismatch mem_data word %0d: got %h expected %h", n, mem_data, want);
                    mismatch_count++;
                end
                @(negedge clk);
            end
            if (mem_valid) begin
                $display("mem_valid still high after the last word");
                other_count++;
            end
        end
        // block_done has rearmed the writer
        expect_level("mult_rdy", mult_rdy, 1'b1);
        expect_level("full", full, 1'b0);
        exp_q.delete();
        draining = 1'b0;
    endtask

    // ==========================================================
    // main sequence
    // ==========================================================
    initial begin
        rst = 1'b1;
        mult_en = 1'b0;
        operands = '0;
        block_read = 1'b0;
        draining = 1'b0;
        mismatch_count = 0;
        other_count = 0;
        last_acc_cycle = 0;
        rng_state = 32'd79220;
        load_table();
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        expect_level("mult_rdy", mult_rdy, 1'b1);
        expect_level("full", full, 1'b0);
        for (int t = 0; t < $size(tests); t++) begin
            fill_block(tests[t]);
            drain_block();
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // worst entry is about 350 cycles
    initial begin
        repeat ($size(tests) * 400) @(posedge clk);
        $display("timeout after %0d cycles, run did not complete", $size(tests) * 400);
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

/* mult_block_top.sv */
`timescale 1ns/100ps
`default_nettype none

module mult_block_top (
    input  logic clk,
    input  logic rst,
    input  logic mult_en,
    input  mult_pkg::operand_pair_u operands,
    output logic mult_rdy,
    output logic full,
    input  logic block_read,
    output logic mem_valid,
    output logic [mult_pkg::PROD_WIDTH-1:0] mem_data
);

    import mult_pkg::*;

    // ==========================================================
    // internal nets
    // ==========================================================
    mem_wr_t wr;
    mem_rd_t rd;
    logic [PROD_WIDTH-1:0] rd_data;
    // reader back to writer, rearms the block
    logic block_done;

    // producer with the multiplier inside
    product_writer i_product_writer (
        .clk        (clk),
        .rst        (rst),
        .mult_en    (mult_en),
        .operands   (operands),
        .block_done (block_done),
        .mult_rdy   (mult_rdy),
        .full       (full),
        .wr         (wr)
    );

    // block buffer
    product_mem i_product_mem (
        .clk     (clk),
        .wr      (wr),
        .rd      (rd),
        .rd_data (rd_data)
    );

    // consumer
    block_reader i_block_reader (
        .clk        (clk),
        .rst        (rst),
        .block_read (block_read),
        .full       (full),
        .rd_data    (rd_data),
        .rd         (rd),
        .mem_valid  (mem_valid),
        .mem_data   (mem_data),
        .block_done (block_done)
    );

endmodule

`default_nettype wire

/* block_reader.sv */
`timescale 1ns/100ps
`default_nettype none

module block_reader (
    input  logic clk,
    input  logic rst,
    input  logic block_read,
    input  logic full,
    input  logic [mult_pkg::PROD_WIDTH-1:0] rd_data,
    output mult_pkg::mem_rd_t rd,
    output logic mem_valid,
    output logic [mult_pkg::PROD_WIDTH-1:0] mem_data,
    output logic block_done
);

    import mult_pkg::*;

    typedef enum logic {
        S_IDLE,
        S_READ
    } state_t;

    state_t state;
    logic [LOGDEPTH-1:0] rd_cnt;
    logic start;

    // idle also means the tail of the last drain is gone,
    // otherwise full is still high for a couple of cycles
    assign start = block_read && full && (state == S_IDLE) && !rd.en && !block_done;

    // ==========================================================
    // fsm and read address
    // ==========================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            rd_cnt <= '0;
            rd <= '0;
            mem_valid <= 1'b0;
            block_done <= 1'b0;
        end else begin
            // data is one cycle behind the address
            mem_valid <= rd.en;
            // flag the word from the last address
            block_done <= rd.en && (rd.addr == LOGDEPTH'(DEPTH - 1));
            case (state)
                S_IDLE: begin
                    rd.en <= 1'b0;
                    if (start) begin
                        state <= S_READ;
                        rd_cnt <= '0;
                    end
                end
                S_READ: begin
                    // one address per cycle, 0 to DEPTH-1
                    rd.en <= 1'b1;
                    rd.addr <= rd_cnt;
                    rd_cnt <= rd_cnt + 1'b1;
                    if (rd_cnt == LOGDEPTH'(DEPTH - 1)) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // memory output register feeds the port directly
    assign mem_data = rd_data;

endmodule

`default_nettype wire

/* product_mem.sv */
`timescale 1ns/100ps
`default_nettype none

module product_mem (
    input  logic clk,
    input  mult_pkg::mem_wr_t wr,
    input  mult_pkg::mem_rd_t rd,
    output logic [mult_pkg::PROD_WIDTH-1:0] rd_data
);

    import mult_pkg::*;

    // ==========================================================
    // storage
    // ==========================================================
    logic [PROD_WIDTH-1:0] mem [DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // read port, one cycle from address to data
    // holds the last word while en is low
    always_ff @(posedge clk) begin
        if (rd.en) begin
            rd_data <= mem[rd.addr];
        end
    end

endmodule

`default_nettype wire

/* product_writer.sv */
`timescale 1ns/100ps
`default_nettype none

module product_writer (
    input  logic clk,
    input  logic rst,
    input  logic mult_en,
    input  mult_pkg::operand_pair_u operands,
    input  logic block_done,
    output logic mult_rdy,
    output logic full,
    output mult_pkg::mem_wr_t wr
);

    import mult_pkg::*;

    // ==========================================================
    // issue side
    // ==========================================================
    // pairs accepted in this block, 0..DEPTH
    logic [LOGDEPTH:0] iss_count;
    logic accept;

    // ready until a whole block has been issued
    assign mult_rdy = (iss_count != (LOGDEPTH+1)'(DEPTH));
    // strobes while not ready are dropped here
    assign accept = mult_en && mult_rdy;

    // multiplier output
    logic mul_valid;
    logic [PROD_WIDTH-1:0] mul_product;

    nibble_multiplier i_nibble_multiplier (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (accept),
        .operands  (operands),
        .out_valid (mul_valid),
        .product   (mul_product)
    );

    // ==========================================================
    // write side
    // ==========================================================
    logic [LOGDEPTH-1:0] wr_addr;

    // products land in order, one address each
    assign wr.en = mul_valid;
    assign wr.addr = wr_addr;
    assign wr.data = mul_product;

    // counts and the full level
    always_ff @(posedge clk) begin
        if (rst || block_done) begin
            // block drained, rearm for the next one
            iss_count <= '0;
            wr_addr <= '0;
            full <= 1'b0;
        end else begin
            if (accept) begin
                iss_count <= iss_count + 1'b1;
            end
            if (mul_valid) begin
                // wraps back to 0 after the last word
                wr_addr <= wr_addr + 1'b1;
                if (wr_addr == LOGDEPTH'(DEPTH - 1)) begin
                    full <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* nibble_multiplier.sv */
`timescale 1ns/100ps
`default_nettype none

module nibble_multiplier (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    input  mult_pkg::operand_pair_u operands,
    output logic out_valid,
    output logic [mult_pkg::PROD_WIDTH-1:0] product
);

    import mult_pkg::*;

    // ==========================================================
    // valid chain, one bit per stage
    // ==========================================================
    logic [MULT_LATENCY-1:0] vld;

    always_ff @(posedge clk) begin
        if (rst) begin
            vld <= '0;
        end else begin
            vld <= {vld[MULT_LATENCY-2:0], in_valid};
        end
    end

    // last stage is the final sum register
    assign out_valid = vld[MULT_LATENCY-1];

    // ==========================================================
    // stage 0: input register
    // ==========================================================
    operand_pair_u opnd_s0;

    always_ff @(posedge clk) begin
        opnd_s0 <= operands;
    end

    // ==========================================================
    // stage 1: rows 0 and 1, forward the rest
    // ==========================================================
    // pp_lo_s1[i][j] = a_i * b_j for i in 0..1
    logic [1:0][3:0][2*NIBBLE-1:0] pp_lo_s1;
    // a2, a3 still needed next stage
    logic [1:0][NIBBLE-1:0] a_hi_s1;
    // all four b digits
    logic [3:0][NIBBLE-1:0] b_s1;

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            for (int j = 0; j < 4; j++) begin
                // a digits sit in nibbles 4..7
                pp_lo_s1[i][j] <= opnd_s0.nib[4+i] * opnd_s0.nib[j];
            end
        end
        a_hi_s1 <= {opnd_s0.nib[7], opnd_s0.nib[6]};
        b_s1 <= opnd_s0.pair.b;
    end

    // ==========================================================
    // stage 2: rows 2 and 3, rows 0 and 1 realigned
    // ==========================================================
    logic [3:0][3:0][2*NIBBLE-1:0] pp_s2;

    always_ff @(posedge clk) begin
        for (int j = 0; j < 4; j++) begin
            pp_s2[0][j] <= pp_lo_s1[0][j];
            pp_s2[1][j] <= pp_lo_s1[1][j];
            pp_s2[2][j] <= a_hi_s1[0] * b_s1[j];
            pp_s2[3][j] <= a_hi_s1[1] * b_s1[j];
        end
    end

    // ==========================================================
    // stage 3: shift each partial by 4*(i+j)
    // ==========================================================
    logic [15:0][PROD_WIDTH-1:0] spp_s3;

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                // zero extend first, then shift
                spp_s3[4*i+j] <= PROD_WIDTH'(pp_s2[i][j]) << (NIBBLE * (i + j));
            end
        end
    end

    // ==========================================================
    // stages 4..7: adder tree, 16 -> 8 -> 4 -> 2 -> 1
    // ==========================================================
    logic [7:0][PROD_WIDTH-1:0] lvl1;
    logic [3:0][PROD_WIDTH-1:0] lvl2;
    logic [1:0][PROD_WIDTH-1:0] lvl3;

    // level 1
    always_ff @(posedge clk) begin
        for (int n = 0; n < 8; n++) begin
            lvl1[n] <= spp_s3[2*n] + spp_s3[2*n+1];
        end
    end

    // level 2
    always_ff @(posedge clk) begin
        for (int n = 0; n < 4; n++) begin
            lvl2[n] <= lvl1[2*n] + lvl1[2*n+1];
        end
    end

    // level 3
    always_ff @(posedge clk) begin
        for (int n = 0; n < 2; n++) begin
            lvl3[n] <= lvl2[2*n] + lvl2[2*n+1];
        end
    end

    // final sum, this is the output register
    // no carry out, 16x16 fits in 32 bits
    always_ff @(posedge clk) begin
        product <= lvl3[0] + lvl3[1];
    end

endmodule

`default_nettype wire

/* mult_pkg.sv */
`default_nettype none

package mult_pkg;

    // ==========================================================
    // sizes
    // ==========================================================

    // product memory address width and block depth
    localparam int LOGDEPTH = 6;
    localparam int DEPTH = 64;

    // operand and product widths
    localparam int OPND_WIDTH = 16;
    localparam int PROD_WIDTH = 32;

    // one digit of the partial product scheme
    localparam int NIBBLE = 4;

    // sampling edge to output register edge
    localparam int MULT_LATENCY = 8;

    // ==========================================================
    // operand word, two views of the same 32 bits
    // ==========================================================

    // pair view, a on top
    typedef struct packed {
        logic [OPND_WIDTH-1:0] a;
        logic [OPND_WIDTH-1:0] b;
    } operand_pair_t;

    // nibble view: digits 0..3 are b, digits 4..7 are a
    typedef union packed {
        operand_pair_t pair;
        logic [2*OPND_WIDTH/NIBBLE-1:0][NIBBLE-1:0] nib;
    } operand_pair_u;

    // ==========================================================
    // memory ports
    // ==========================================================

    // producer side
    typedef struct packed {
        logic en;
        logic [LOGDEPTH-1:0] addr;
        logic [PROD_WIDTH-1:0] data;
    } mem_wr_t;

    // consumer side
    typedef struct packed {
        logic en;
        logic [LOGDEPTH-1:0] addr;
    } mem_rd_t;

endpackage

`default_nettype wire
